// ==== design/histPkg.sv ====
package histPkg;

    // histogram geometry
    localparam int BIN_BITS = 6;
    localparam int NUM_BINS = 64;
    localparam int COUNT_BITS = 8;      // counts saturate at 255

    // acquisition length in accepted events
    localparam int TARGET_BITS = 16;

    // wishbone bus widths
    localparam int WB_ADR_BITS = 8;
    localparam int WB_DATA_BITS = 16;

    // register map, word addresses
    localparam logic [WB_ADR_BITS-1:0] ADR_CTRL = 8'd0;     // bit 0 starts a run
    localparam logic [WB_ADR_BITS-1:0] ADR_STATUS = 8'd1;   // {done, busy}
    localparam logic [WB_ADR_BITS-1:0] ADR_TARGET = 8'd2;

    // bin k sits at ADR_BIN_BASE + k
    localparam logic [WB_ADR_BITS-1:0] ADR_BIN_BASE = 8'd64;

    // acquisition controller states
    typedef enum logic [1:0] {
        stIdle  = 2'd0,     // waiting for start
        stClear = 2'd1,     // zero sweep over all bins
        stCount = 2'd2,     // event read-modify-write
        stDone  = 2'd3      // histogram ready for readout
    } CtrlState;

endpackage

// ==== design/histRam.sv ====
`timescale 1ns/1ps

module histRam (
    input  logic                            clk,
    input  logic                            wEnable,
    input  logic [histPkg::BIN_BITS-1:0]    waddr,
    input  logic [histPkg::COUNT_BITS-1:0]  newCounts,
    input  logic                            rEnable,
    input  logic [histPkg::BIN_BITS-1:0]    raddr,
    output logic [histPkg::COUNT_BITS-1:0]  counts
);

    logic [histPkg::COUNT_BITS-1:0] mem [histPkg::NUM_BINS];  // one count per bin

    // port A, write only
    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= newCounts;
        end
    end

    // port B, registered read
    // a read of the address being written returns the old count
    always_ff @(posedge clk) begin
        if (rEnable) begin
            counts <= mem[raddr];
        end
    end

endmodule

// ==== design/histCtrl.sv ====
`timescale 1ns/1ps

module histCtrl (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            startPulse,
    input  logic [histPkg::TARGET_BITS-1:0] acqTarget,
    input  logic                            eventValid,
    input  logic [histPkg::BIN_BITS-1:0]    eventBin,
    output logic                            eventReady,
    input  logic [histPkg::COUNT_BITS-1:0]  counts,
    output logic                            wEnable,
    output logic [histPkg::BIN_BITS-1:0]    waddr,
    output logic [histPkg::COUNT_BITS-1:0]  newCounts,
    output logic                            rEnable,
    output logic [histPkg::BIN_BITS-1:0]    raddr,
    output logic                            busy,
    output logic                            done
);

    histPkg::CtrlState state;
    histPkg::CtrlState nextState;

    logic [histPkg::BIN_BITS-1:0]    clrAddr;       // clear sweep pointer
    logic [histPkg::TARGET_BITS-1:0] acceptCnt;     // events taken this run
    logic                            targetReached;
    logic                            accept;

    // write stage, one edge behind the read
    logic                            pending;       // write due this cycle
    logic [histPkg::BIN_BITS-1:0]    pendBin;

    // last write, kept for back-to-back hits on one bin
    logic                            fwdValid;
    logic [histPkg::BIN_BITS-1:0]    fwdBin;
    logic [histPkg::COUNT_BITS-1:0]  fwdCount;

    logic [histPkg::COUNT_BITS-1:0]  baseCount;
    logic [histPkg::COUNT_BITS-1:0]  incCount;

    assign targetReached = (acceptCnt >= acqTarget);
    assign eventReady = (state == histPkg::stCount) && !targetReached;
    assign accept = eventValid && eventReady;

    assign busy = (state == histPkg::stClear) || (state == histPkg::stCount);
    assign done = (state == histPkg::stDone);

    // read side of the read-modify-write
    assign rEnable = accept;
    assign raddr = eventBin;

    // memory still holds the old value when the previous write hit this bin
    assign baseCount = (fwdValid && (fwdBin == pendBin)) ? fwdCount : counts;
    assign incCount = (baseCount == '1) ? baseCount : baseCount + 1'b1;  // saturate

    // write side, zeros during the sweep
    always_comb begin
        if (state == histPkg::stClear) begin
            wEnable = 1'b1;
            waddr = clrAddr;
            newCounts = '0;
        end else begin
            wEnable = pending;
            waddr = pendBin;
            newCounts = incCount;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            histPkg::stIdle: begin
                if (startPulse) begin
                    nextState = histPkg::stClear;
                end
            end
            histPkg::stClear: begin
                if (clrAddr == histPkg::BIN_BITS'(histPkg::NUM_BINS - 1)) begin
                    nextState = histPkg::stCount;
                end
            end
            histPkg::stCount: begin
                // last write lands on the same edge that leaves count
                if (targetReached) begin
                    nextState = histPkg::stDone;
                end
            end
            histPkg::stDone: begin
                if (startPulse) begin
                    nextState = histPkg::stClear;
                end
            end
            default: nextState = histPkg::stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= histPkg::stIdle;
            clrAddr <= '0;
            acceptCnt <= '0;
            pending <= 1'b0;
            fwdValid <= 1'b0;
        end else begin
            state <= nextState;

            if (state == histPkg::stClear) begin
                clrAddr <= clrAddr + 1'b1;  // wraps to 0 after the last bin
            end else begin
                clrAddr <= '0;
            end

            if (state == histPkg::stClear) begin
                acceptCnt <= '0;
            end else if (accept) begin
                acceptCnt <= acceptCnt + 1'b1;
            end

            pending <= accept;
            fwdValid <= pending;
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        if (accept) begin
            pendBin <= eventBin;
        end
        if (pending) begin
            fwdBin <= pendBin;
            fwdCount <= incCount;
        end
    end

endmodule

// ==== design/histWbSlave.sv ====
`timescale 1ns/1ps

module histWbSlave (
    input  logic                             clk,
    input  logic                             res,
    input  logic                             wbCyc,
    input  logic                             wbStb,
    input  logic                             wbWe,
    input  logic [histPkg::WB_ADR_BITS-1:0]  wbAdr,
    input  logic [histPkg::WB_DATA_BITS-1:0] wbDatIn,
    output logic [histPkg::WB_DATA_BITS-1:0] wbDatOut,
    output logic                             wbAck,
    output logic                             startPulse,
    output logic [histPkg::TARGET_BITS-1:0]  acqTarget,
    input  logic                             busy,
    input  logic                             done,
    output logic [histPkg::BIN_BITS-1:0]     binAddr,
    output logic                             binReadEnable,
    input  logic [histPkg::COUNT_BITS-1:0]   counts
);

    logic request;      // new transfer, not yet acknowledged
    logic isBin;
    logic regAccess;    // one-cycle ack path
    logic readPending;  // memory read in flight

    assign request = wbCyc && wbStb && !wbAck;
    assign isBin = (wbAdr >= histPkg::ADR_BIN_BASE) &&
                   (wbAdr < histPkg::ADR_BIN_BASE + histPkg::NUM_BINS);

    // bin window writes take the register path and are dropped
    assign regAccess = request && (!isBin || wbWe);

    assign binAddr = histPkg::BIN_BITS'(wbAdr - histPkg::ADR_BIN_BASE);

    // the read port belongs to the controller while busy, so hold off
    assign binReadEnable = request && isBin && !wbWe && !busy && !readPending;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wbAck <= 1'b0;
            startPulse <= 1'b0;
            acqTarget <= '0;
            readPending <= 1'b0;
        end else begin
            wbAck <= 1'b0;
            startPulse <= 1'b0;

            if (readPending) begin
                wbAck <= 1'b1;          // count arrived this cycle
                readPending <= 1'b0;
            end else if (regAccess) begin
                wbAck <= 1'b1;
                if (wbWe) begin
                    if (wbAdr == histPkg::ADR_CTRL) begin
                        startPulse <= wbDatIn[0];
                    end
                    if (wbAdr == histPkg::ADR_TARGET) begin
                        acqTarget <= wbDatIn[histPkg::TARGET_BITS-1:0];
                    end
                end
            end else if (binReadEnable) begin
                readPending <= 1'b1;
            end
        end
    end

    // read data, valid with the ack
    always_ff @(posedge clk) begin
        if (readPending) begin
            wbDatOut <= histPkg::WB_DATA_BITS'(counts);
        end else if (regAccess && !wbWe) begin
            case (wbAdr)
                histPkg::ADR_STATUS: wbDatOut <= histPkg::WB_DATA_BITS'({done, busy});
                histPkg::ADR_TARGET: wbDatOut <= histPkg::WB_DATA_BITS'(acqTarget);
                default:             wbDatOut <= '0;   // ctrl reads back zero
            endcase
        end
    end

endmodule

// ==== design/histTop.sv ====
`timescale 1ns/1ps

module histTop (
    input  logic                             clk,
    input  logic                             res,
    input  logic                             wbCyc,
    input  logic                             wbStb,
    input  logic                             wbWe,
    input  logic [histPkg::WB_ADR_BITS-1:0]  wbAdr,
    input  logic [histPkg::WB_DATA_BITS-1:0] wbDatIn,
    output logic [histPkg::WB_DATA_BITS-1:0] wbDatOut,
    output logic                             wbAck,
    input  logic                             eventValid,
    input  logic [histPkg::BIN_BITS-1:0]     eventBin,
    output logic                             eventReady
);

    logic                            startPulse;
    logic [histPkg::TARGET_BITS-1:0] acqTarget;
    logic                            busy;
    logic                            done;

    logic                            wEnable;
    logic [histPkg::BIN_BITS-1:0]    waddr;
    logic [histPkg::COUNT_BITS-1:0]  newCounts;
    logic [histPkg::COUNT_BITS-1:0]  counts;

    // read port B, shared
    logic                            ctrlREnable;
    logic [histPkg::BIN_BITS-1:0]    ctrlRaddr;
    logic                            binReadEnable;
    logic [histPkg::BIN_BITS-1:0]    binAddr;
    logic                            rEnable;
    logic [histPkg::BIN_BITS-1:0]    raddr;

    // controller owns port B for the whole run
    assign rEnable = busy ? ctrlREnable : binReadEnable;
    assign raddr = busy ? ctrlRaddr : binAddr;

    histCtrl uCtrl (
        .clk        (clk),
        .res        (res),
        .startPulse (startPulse),
        .acqTarget  (acqTarget),
        .eventValid (eventValid),
        .eventBin   (eventBin),
        .eventReady (eventReady),
        .counts     (counts),
        .wEnable    (wEnable),
        .waddr      (waddr),
        .newCounts  (newCounts),
        .rEnable    (ctrlREnable),
        .raddr      (ctrlRaddr),
        .busy       (busy),
        .done       (done)
    );

    histRam uRam (
        .clk        (clk),
        .wEnable    (wEnable),
        .waddr      (waddr),
        .newCounts  (newCounts),
        .rEnable    (rEnable),
        .raddr      (raddr),
        .counts     (counts)
    );

    histWbSlave uWb (
        .clk           (clk),
        .res           (res),
        .wbCyc         (wbCyc),
        .wbStb         (wbStb),
        .wbWe          (wbWe),
        .wbAdr         (wbAdr),
        .wbDatIn       (wbDatIn),
        .wbDatOut      (wbDatOut),
        .wbAck         (wbAck),
        .startPulse    (startPulse),
        .acqTarget     (acqTarget),
        .busy          (busy),
        .done          (done),
        .binAddr       (binAddr),
        .binReadEnable (binReadEnable),
        .counts        (counts)
    );

endmodule

// ==== verif/histCtrl_asserts.sv ====
`timescale 1ns/1ps

module histCtrlAsserts (
    input logic                         clk,
    input logic                         res,
    input histPkg::CtrlState            state,
    input logic                         eventReady,
    input logic                         wEnable,
    input logic [histPkg::BIN_BITS-1:0] waddr,
    input logic                         busy,
    input logic                         done
);

    int failCount = 0;  // read by the testbench at the end

    assert property (@(posedge clk) disable iff (!res)
        eventReady |-> (state == histPkg::stCount))
        else begin
            failCount++;
            $error("eventReady high outside count");
        end

    assert property (@(posedge clk) disable iff (!res)
        (state == histPkg::stIdle) |-> !wEnable)
        else begin
            failCount++;
            $error("memory write while idle");
        end

    assert property (@(posedge clk) disable iff (!res) !(busy && done))
        else begin
            failCount++;
            $error("busy and done high together");
        end

    // sweep starts at bin 0 and steps by one
    assert property (@(posedge clk) disable iff (!res)
        (state == histPkg::stClear && $past(state) != histPkg::stClear) |-> (waddr == '0))
        else begin
            failCount++;
            $error("clear sweep does not start at bin 0");
        end

    assert property (@(posedge clk) disable iff (!res)
        (state == histPkg::stClear && $past(state) == histPkg::stClear)
        |-> (waddr == histPkg::BIN_BITS'($past(waddr) + 1'b1)))
        else begin
            failCount++;
            $error("clear sweep address skipped");
        end

endmodule

bind histCtrl histCtrlAsserts uAsserts (
    .clk(clk), .res(res), .state(state), .eventReady(eventReady),
    .wEnable(wEnable), .waddr(waddr), .busy(busy), .done(done)
);

// ==== verif/histTb.sv ====
`timescale 1ns/1ps

module histTb;

    // five runs, about 1500 event cycles, 5 sweeps of 64 and 5 bin readouts of ~320
    // cycles plus polling come to roughly 4000 cycles, so 5x margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                             clk;
    logic                             res;
    logic                             wbCyc;
    logic                             wbStb;
    logic                             wbWe;
    logic [histPkg::WB_ADR_BITS-1:0]  wbAdr;
    logic [histPkg::WB_DATA_BITS-1:0] wbDatIn;
    logic [histPkg::WB_DATA_BITS-1:0] wbDatOut;
    logic                             wbAck;
    logic                             eventValid;
    logic [histPkg::BIN_BITS-1:0]     eventBin;
    logic                             eventReady;

    integer seed = 32'h8807_d551;
    int     errors = 0;
    int     checks = 0;
    int     cycleCount = 0;
    int     accepted = 0;                           // events taken in this run
    logic [histPkg::COUNT_BITS-1:0] model [histPkg::NUM_BINS];

    // event source control
    logic                         offerOn = 1'b0;
    int                           gapPct = 0;
    int                           binMode = 0;      // 0 random, 1 two bins, 2 one bin
    logic [histPkg::BIN_BITS-1:0] binA = '0;
    logic [histPkg::BIN_BITS-1:0] binB = '0;

    histTop dut (
        .clk(clk), .res(res),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatIn(wbDatIn), .wbDatOut(wbDatOut), .wbAck(wbAck),
        .eventValid(eventValid), .eventBin(eventBin), .eventReady(eventReady)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : watchdog
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    // events and the reference model
    initial begin : eventSource
        logic took;
        int   r;
        eventValid = 1'b0;
        eventBin = '0;
        forever begin
            @(negedge clk);
            took = eventValid && eventReady;   // taken on the coming edge
            if (took) begin
                if (model[eventBin] != 8'd255) begin
                    model[eventBin] = model[eventBin] + 8'd1;
                end
                accepted++;
            end
            @(posedge clk);
            if (!offerOn) begin
                eventValid <= 1'b0;
            end else if (took || !eventValid) begin
                if ($unsigned($random(seed)) % 100 < gapPct) begin
                    eventValid <= 1'b0;
                end else begin
                    r = $random(seed);
                    eventValid <= 1'b1;
                    case (binMode)
                        0: eventBin <= histPkg::BIN_BITS'(r);
                        1: eventBin <= r[0] ? binA : binB;
                        default: eventBin <= binA;
                    endcase
                end
            end
        end
    end

    task automatic checkValue(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic wbWrite(input logic [7:0] adr, input logic [15:0] data);
        @(posedge clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= 1'b1;
        wbAdr <= adr;
        wbDatIn <= data;
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe <= 1'b0;
    endtask

    task automatic wbRead(input logic [7:0] adr, output logic [15:0] data);
        @(posedge clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe <= 1'b0;
        wbAdr <= adr;
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        data = wbDatOut;                    // valid with the ack
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
    endtask

    // the sweep zeroes every bin, so the model starts empty
    task automatic startRun(input logic [15:0] target);
        wbWrite(histPkg::ADR_TARGET, target);
        for (int k = 0; k < histPkg::NUM_BINS; k++) begin
            model[k] = '0;
        end
        accepted = 0;
        wbWrite(histPkg::ADR_CTRL, 16'h0001);
    endtask

    task automatic waitForDone();
        logic [15:0] st;
        st = '0;
        while (!st[1]) wbRead(histPkg::ADR_STATUS, st);
    endtask

    task automatic checkHistogram(output int sum);
        logic [15:0] d;
        sum = 0;
        for (int k = 0; k < histPkg::NUM_BINS; k++) begin
            wbRead(histPkg::WB_ADR_BITS'(histPkg::ADR_BIN_BASE + k), d);
            checkValue($sformatf("bin %0d", k), int'(d), int'(model[k]));
            sum += int'(d);
        end
    endtask

    initial begin : mainSequence
        logic [15:0] d;
        logic [15:0] st;
        int          sum;
        int          assertFails;
        res = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatIn = '0;
        for (int k = 0; k < histPkg::NUM_BINS; k++) begin
            model[k] = '0;
        end
        repeat (4) @(posedge clk);
        res <= 1'b1;

        wbRead(histPkg::ADR_STATUS, d);
        checkValue("status after reset", int'(d), 0);
        offerOn = 1'b1;                     // nothing may be taken before a start
        repeat (20) @(posedge clk);
        offerOn = 1'b0;
        checkValue("events accepted before start", accepted, 0);
        wbWrite(histPkg::ADR_TARGET, 16'hA5C3);
        wbRead(histPkg::ADR_TARGET, d);
        checkValue("target readback", int'(d), 16'hA5C3);

        // random histogram, then offers while done
        gapPct = 30;
        binMode = 0;
        offerOn = 1'b1;
        startRun(16'd600);
        waitForDone();
        repeat (20) @(posedge clk);
        offerOn = 1'b0;                     // drop the held offer before the next run
        checkValue("events accepted", accepted, 600);
        checkHistogram(sum);
        checkValue("bin total", sum, 600);
        wbRead(histPkg::ADR_STATUS, st);
        checkValue("status after run", int'(st), 2);

        // back to back on two bins exercises forwarding
        gapPct = 0;
        binMode = 1;
        binA = 6'd17;
        binB = 6'd18;
        offerOn = 1'b1;
        startRun(16'd200);
        waitForDone();
        offerOn = 1'b0;
        checkHistogram(sum);
        checkValue("bin total", sum, 200);

        binMode = 2;
        binA = 6'd9;
        offerOn = 1'b1;
        startRun(16'd300);
        waitForDone();
        checkHistogram(sum);
        wbRead(histPkg::WB_ADR_BITS'(histPkg::ADR_BIN_BASE + 9), d);
        checkValue("saturated bin", int'(d), 255);

        // zero target leaves only the sweep
        offerOn = 1'b0;
        startRun(16'd0);
        waitForDone();
        checkHistogram(sum);
        checkValue("bin total after clear", sum, 0);
        wbRead(histPkg::ADR_STATUS, st);
        checkValue("status after clear run", int'(st), 2);

        // bin read issued while busy is held until done
        gapPct = 25;
        binMode = 0;
        offerOn = 1'b1;
        startRun(16'd100);
        wbRead(histPkg::WB_ADR_BITS'(histPkg::ADR_BIN_BASE + 3), d);
        wbRead(histPkg::ADR_STATUS, st);
        checkValue("status after held read", int'(st), 2);
        checkValue("held bin read", int'(d), int'(model[3]));
        offerOn = 1'b0;
        checkHistogram(sum);
        checkValue("events accepted", accepted, 100);

        assertFails = dut.uCtrl.uAsserts.failCount;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== histTop.f ====
design/histPkg.sv
design/histRam.sv
design/histCtrl.sv
design/histWbSlave.sv
design/histTop.sv
verif/histCtrl_asserts.sv
verif/histTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = histTb
FILELIST = histTop.f
SIM_OPTS = +verilator+error+limit+1000
PASS_MSG = Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only if the pass message shows up in the output
sim: build
	@out="$$(./obj_dir/V$(TOP) $(SIM_OPTS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
